// File: hw/fe_pkg.sv
package fe_pkg;

	localparam int REG_W = 5;
	localparam int CSR_W = 12;

	// rv32i major opcodes, instr[6:0].
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	typedef enum logic [3:0] {
		op_alu,
		op_alu_imm,
		op_load,
		op_store,
		op_branch,
		op_jal,
		op_jalr,
		op_lui,
		op_auipc,
		op_csr,
		op_ebreak,
		op_illegal
	} opcode_e;

	typedef enum logic [1:0] {
		st_idle,          // ready to issue the next request.
		st_wait_rsp,      // one request is outstanding.
		st_hold,          // response parked in the buffer.
		st_wait_redirect  // control instruction passed on.
	} fetch_state_e;

endpackage

// File: hw/fe_req_if.sv
`timescale 1ns/1ps

interface fe_req_if;
	import fe_pkg::*;

	logic             valid;
	logic [31:0]      pc;
	opcode_e          opcode;
	logic [REG_W-1:0] rd;
	logic [REG_W-1:0] rs1;
	logic [REG_W-1:0] rs2;
	logic [2:0]       funct3;
	logic [31:0]      imm;
	logic [CSR_W-1:0] csr_address;
	logic             wb; // the instruction writes rd.

	modport producer (
		output valid,
		output pc,
		output opcode,
		output rd,
		output rs1,
		output rs2,
		output funct3,
		output imm,
		output csr_address,
		output wb
	);

	modport consumer (
		input valid,
		input pc,
		input opcode,
		input rd,
		input rs1,
		input rs2,
		input funct3,
		input imm,
		input csr_address,
		input wb
	);

endinterface

// File: hw/fe_fetch.sv
`timescale 1ns/1ps

module fe_fetch #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        freeze,
	input  logic        ctrl_stall,
	input  logic        redirect_valid,
	input  logic [31:0] redirect_pc,
	output logic        icache_req_valid,
	output logic [31:0] icache_req_addr,
	input  logic        icache_rsp_valid,
	input  logic [31:0] icache_rsp_data,
	output logic        fetch_valid,
	output logic [31:0] fetch_pc,
	output logic [31:0] fetch_instr,
	output logic        fetch_delay
);
	import fe_pkg::*;

	fetch_state_e state_q;
	logic [31:0]  pc_q;      // address of the word in flight or next to fetch.
	logic [31:0]  buf_q;
	logic         discard_q; // the outstanding response belongs to an old path.
	logic         boot_q;
	logic         rsp_live;

	// Requests start one cycle after reset is released.
	assign icache_req_valid = boot_q && state_q == st_idle && !freeze && !ctrl_stall
		&& !redirect_valid;
	assign icache_req_addr = pc_q;

	assign rsp_live = state_q == st_wait_rsp && icache_rsp_valid && !discard_q;

	assign fetch_valid = !freeze && !redirect_valid && (rsp_live || state_q == st_hold);
	assign fetch_pc = pc_q;
	assign fetch_instr = (state_q == st_hold) ? buf_q : icache_rsp_data;
	assign fetch_delay = state_q == st_wait_rsp || state_q == st_hold;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= st_idle;
			pc_q <= RESET_PC;
			discard_q <= 1'b0;
			boot_q <= 1'b0;
		end else begin
			boot_q <= 1'b1;
			case (state_q)
				st_idle: begin
					if (redirect_valid) begin
						pc_q <= redirect_pc;
					end else if (icache_req_valid) begin
						state_q <= st_wait_rsp;
					end else if (ctrl_stall) begin
						state_q <= st_wait_redirect; // decode holds a control instruction.
					end
				end
				st_wait_rsp: begin
					if (redirect_valid) begin
						pc_q <= redirect_pc;
						if (icache_rsp_valid) begin
							state_q <= st_idle;
							discard_q <= 1'b0;
						end else begin
							discard_q <= 1'b1; // wait for the stale response to drain.
						end
					end else if (icache_rsp_valid) begin
						if (discard_q) begin
							discard_q <= 1'b0;
							state_q <= st_idle;
						end else if (freeze) begin
							state_q <= st_hold;
						end else begin
							pc_q <= pc_q + 32'd4;
							state_q <= st_idle;
						end
					end
				end
				st_hold: begin
					if (redirect_valid) begin
						pc_q <= redirect_pc;
						state_q <= st_idle;
					end else if (!freeze) begin
						pc_q <= pc_q + 32'd4;
						state_q <= st_idle;
					end
				end
				default: begin
					if (redirect_valid) begin
						pc_q <= redirect_pc;
						state_q <= st_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_live) begin
			buf_q <= icache_rsp_data;
		end
	end

endmodule

// File: hw/fe_fd_reg.sv
`timescale 1ns/1ps

module fe_fd_reg (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        hold,
	input  logic        flush,
	input  logic        fetch_valid,
	input  logic [31:0] fetch_pc,
	input  logic [31:0] fetch_instr,
	output logic        fd_valid,
	output logic [31:0] fd_pc,
	output logic [31:0] fd_instr
);

	// flush wins over hold so a redirect always empties the stage.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fd_valid <= 1'b0;
		end else if (flush) begin
			fd_valid <= 1'b0;
		end else if (!hold) begin
			fd_valid <= fetch_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			fd_pc <= fetch_pc;
			fd_instr <= fetch_instr;
		end
	end

endmodule

// File: hw/fe_decode.sv
`timescale 1ns/1ps

module fe_decode (
	input  logic        fd_valid,
	input  logic [31:0] fd_pc,
	input  logic [31:0] fd_instr,
	fe_req_if.producer  req,
	output logic        ctrl_stall
);
	import fe_pkg::*;

	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic        is_ebreak;

	assign imm_i = {{20{fd_instr[31]}}, fd_instr[31:20]};
	assign imm_s = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
	assign imm_b = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7], fd_instr[30:25],
		fd_instr[11:8], 1'b0};
	assign imm_u = {fd_instr[31:12], 12'h000};
	assign imm_j = {{11{fd_instr[31]}}, fd_instr[31], fd_instr[19:12], fd_instr[20],
		fd_instr[30:21], 1'b0};

	assign is_ebreak = fd_instr[31:20] == 12'h001 && fd_instr[19:7] == 13'h0000;

	assign req.valid = fd_valid;
	assign req.pc = fd_pc;
	assign req.rd = fd_instr[11:7];
	assign req.rs1 = fd_instr[19:15];
	assign req.rs2 = fd_instr[24:20];
	assign req.funct3 = fd_instr[14:12];
	assign req.csr_address = fd_instr[31:20];

	always_comb begin
		req.opcode = op_illegal;
		req.imm = 32'h0000_0000;
		case (fd_instr[6:0])
			OPC_OP: req.opcode = op_alu;
			OPC_OP_IMM: begin
				req.opcode = op_alu_imm;
				req.imm = imm_i;
			end
			OPC_LOAD: begin
				req.opcode = op_load;
				req.imm = imm_i;
			end
			OPC_STORE: begin
				req.opcode = op_store;
				req.imm = imm_s;
			end
			OPC_BRANCH: begin
				req.opcode = op_branch;
				req.imm = imm_b;
			end
			OPC_JAL: begin
				req.opcode = op_jal;
				req.imm = imm_j;
			end
			OPC_JALR: begin
				req.opcode = op_jalr;
				req.imm = imm_i;
			end
			OPC_LUI: begin
				req.opcode = op_lui;
				req.imm = imm_u;
			end
			OPC_AUIPC: begin
				req.opcode = op_auipc;
				req.imm = imm_u;
			end
			OPC_SYSTEM: begin
				// ecall and the other funct3 zero encodings stay illegal.
				if (fd_instr[14:12] != 3'b000) begin
					req.opcode = op_csr;
					req.imm = imm_i;
				end else if (is_ebreak) begin
					req.opcode = op_ebreak;
					req.imm = imm_i;
				end
			end
			default: req.opcode = op_illegal;
		endcase
	end

	assign req.wb = req.opcode inside {op_alu, op_alu_imm, op_load, op_jal, op_jalr, op_lui,
		op_auipc, op_csr};

	assign ctrl_stall = fd_valid && req.opcode inside {op_branch, op_jal, op_jalr};

endmodule

// File: hw/fe_de_reg.sv
`timescale 1ns/1ps

module fe_de_reg (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       hold,
	input  logic       bubble,
	fe_req_if.consumer req_in,
	fe_req_if.producer req_out,
	output logic       ebreak
);
	import fe_pkg::*;

	logic fresh_q; // output was loaded on the last edge.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req_out.valid <= 1'b0;
			fresh_q <= 1'b0;
		end else begin
			fresh_q <= !hold;
			if (!hold) begin
				req_out.valid <= req_in.valid && !bubble;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			req_out.pc <= req_in.pc;
			req_out.opcode <= req_in.opcode;
			req_out.rd <= req_in.rd;
			req_out.rs1 <= req_in.rs1;
			req_out.rs2 <= req_in.rs2;
			req_out.funct3 <= req_in.funct3;
			req_out.imm <= req_in.imm;
			req_out.csr_address <= req_in.csr_address;
			req_out.wb <= req_in.wb;
		end
	end

	// one pulse per ebreak, even when the back end holds the stage.
	assign ebreak = req_out.valid && fresh_q && req_out.opcode == op_ebreak;

endmodule

// File: hw/front_end.sv
`timescale 1ns/1ps

module front_end #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     freeze,
	input  logic                     exe_branch_stall,
	input  logic                     redirect_valid,
	input  logic [31:0]              redirect_pc,
	output logic                     icache_req_valid,
	output logic [31:0]              icache_req_addr,
	input  logic                     icache_rsp_valid,
	input  logic [31:0]              icache_rsp_data,
	output logic                     fetch_delay,
	output logic                     fetch_ebreak,
	output logic                     bck_req_valid,
	output logic [31:0]              bck_pc,
	output fe_pkg::opcode_e          bck_opcode,
	output logic [fe_pkg::REG_W-1:0] bck_rd,
	output logic [fe_pkg::REG_W-1:0] bck_rs1,
	output logic [fe_pkg::REG_W-1:0] bck_rs2,
	output logic [2:0]               bck_funct3,
	output logic [31:0]              bck_imm,
	output logic [fe_pkg::CSR_W-1:0] bck_csr_address,
	output logic                     bck_wb
);

	logic        fd_hold; // also stops fetch, or a passed response would be lost.
	logic        ctrl_stall;
	logic        fetch_valid;
	logic [31:0] fetch_pc;
	logic [31:0] fetch_instr;
	logic        fd_valid;
	logic [31:0] fd_pc;
	logic [31:0] fd_instr;

	fe_req_if dec_req ();
	fe_req_if bck_req ();

	assign fd_hold = freeze || exe_branch_stall;

	fe_fetch #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clk             (clk),
		.arst_n          (arst_n),
		.freeze          (fd_hold),
		.ctrl_stall      (ctrl_stall),
		.redirect_valid  (redirect_valid),
		.redirect_pc     (redirect_pc),
		.icache_req_valid(icache_req_valid),
		.icache_req_addr (icache_req_addr),
		.icache_rsp_valid(icache_rsp_valid),
		.icache_rsp_data (icache_rsp_data),
		.fetch_valid     (fetch_valid),
		.fetch_pc        (fetch_pc),
		.fetch_instr     (fetch_instr),
		.fetch_delay     (fetch_delay)
	);

	fe_fd_reg u_fd_reg (
		.clk        (clk),
		.arst_n     (arst_n),
		.hold       (fd_hold),
		.flush      (redirect_valid),
		.fetch_valid(fetch_valid),
		.fetch_pc   (fetch_pc),
		.fetch_instr(fetch_instr),
		.fd_valid   (fd_valid),
		.fd_pc      (fd_pc),
		.fd_instr   (fd_instr)
	);

	fe_decode u_decode (
		.fd_valid  (fd_valid),
		.fd_pc     (fd_pc),
		.fd_instr  (fd_instr),
		.req       (dec_req.producer),
		.ctrl_stall(ctrl_stall)
	);

	fe_de_reg u_de_reg (
		.clk    (clk),
		.arst_n (arst_n),
		.hold   (freeze),
		.bubble (exe_branch_stall),
		.req_in (dec_req.consumer),
		.req_out(bck_req.producer),
		.ebreak (fetch_ebreak)
	);

	assign bck_req_valid = bck_req.valid;
	assign bck_pc = bck_req.pc;
	assign bck_opcode = bck_req.opcode;
	assign bck_rd = bck_req.rd;
	assign bck_rs1 = bck_req.rs1;
	assign bck_rs2 = bck_req.rs2;
	assign bck_funct3 = bck_req.funct3;
	assign bck_imm = bck_req.imm;
	assign bck_csr_address = bck_req.csr_address;
	assign bck_wb = bck_req.wb;

endmodule

// File: verif/front_end_sva.sv
`timescale 1ns/1ps

module front_end_sva (
	input logic clk,
	input logic arst_n,
	input logic freeze,
	input logic exe_branch_stall,
	input logic redirect_valid,
	input logic icache_req_valid,
	input logic icache_rsp_valid,
	input logic bck_req_valid
);

	logic out_q;   // a cache request is outstanding.
	logic stale_q; // its response belongs to a path left by a redirect.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_q <= 1'b0;
			stale_q <= 1'b0;
		end else begin
			if (icache_req_valid) begin
				out_q <= 1'b1;
			end else if (icache_rsp_valid) begin
				out_q <= 1'b0;
			end
			if (icache_rsp_valid) begin
				stale_q <= 1'b0;
			end else if (redirect_valid && out_q) begin
				stale_q <= 1'b1;
			end
		end
	end

	one_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
		icache_req_valid |-> !out_q)
		else $error("cache request issued while another is outstanding");

	no_req_in_freeze: assert property (@(posedge clk) disable iff (!arst_n)
		freeze |-> !icache_req_valid)
		else $error("cache request issued during freeze");

	rsp_to_output: assert property (@(posedge clk) disable iff (!arst_n)
		(icache_rsp_valid && out_q && !stale_q && !freeze && !exe_branch_stall
			&& !redirect_valid) ##1 (!freeze && !exe_branch_stall) |=> bck_req_valid)
		else $error("response did not reach the back end two cycles later");

endmodule

bind front_end front_end_sva u_sva (
	.clk             (clk),
	.arst_n          (arst_n),
	.freeze          (freeze),
	.exe_branch_stall(exe_branch_stall),
	.redirect_valid  (redirect_valid),
	.icache_req_valid(icache_req_valid),
	.icache_rsp_valid(icache_rsp_valid),
	.bck_req_valid   (bck_req_valid)
);

// File: verif/tb_front_end.sv
`timescale 1ns/1ps

module tb_front_end;
	import fe_pkg::*;

	localparam logic [31:0] RESET_PC = 32'h0000_0400;
	localparam int N_REQ = 400;

	typedef struct packed {
		opcode_e          opcode;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rs1;
		logic [REG_W-1:0] rs2;
		logic [2:0]       funct3;
		logic [31:0]      imm;
		logic [CSR_W-1:0] csr_address;
		logic             wb;
	} fields_t;

	logic             clk;
	logic             arst_n;
	logic             freeze;
	logic             exe_branch_stall;
	logic             redirect_valid;
	logic [31:0]      redirect_pc;
	logic             icache_req_valid;
	logic [31:0]      icache_req_addr;
	logic             icache_rsp_valid;
	logic [31:0]      icache_rsp_data;
	logic             fetch_delay;
	logic             fetch_ebreak;
	logic             bck_req_valid;
	logic [31:0]      bck_pc;
	opcode_e          bck_opcode;
	logic [REG_W-1:0] bck_rd;
	logic [REG_W-1:0] bck_rs1;
	logic [REG_W-1:0] bck_rs2;
	logic [2:0]       bck_funct3;
	logic [31:0]      bck_imm;
	logic [CSR_W-1:0] bck_csr_address;
	logic             bck_wb;

	logic [31:0] lfsr;
	logic [31:0] image [logic [31:0]]; // program words by byte address.
	int          err_count;
	int          accepted;
	int          class_count [0:15];
	logic [31:0] exp_pc;
	logic        redirect_pending;   // a control instruction left, its redirect has not.
	logic        ebreak_pulse_seen;
	logic        first_req_seen;
	fields_t     prev_out;
	logic        prev_valid;
	logic [31:0] prev_pc;
	logic        prev_freeze;
	logic        prev_stall;
	int          rsp_cnt;
	int          redir_cnt;
	logic [31:0] rsp_addr;
	logic [31:0] redir_target;
	logic        timed_out;
	int          cycles;
	int          idle_cycles;
	int          last_accepted;
	logic        rsp_open;   // a cache request is outstanding.
	logic        rsp_stale;
	logic        rsp_parked; // a response waits in the fetch buffer.

	front_end #(
		.RESET_PC(RESET_PC)
	) u_dut (
		.clk             (clk),
		.arst_n          (arst_n),
		.freeze          (freeze),
		.exe_branch_stall(exe_branch_stall),
		.redirect_valid  (redirect_valid),
		.redirect_pc     (redirect_pc),
		.icache_req_valid(icache_req_valid),
		.icache_req_addr (icache_req_addr),
		.icache_rsp_valid(icache_rsp_valid),
		.icache_rsp_data (icache_rsp_data),
		.fetch_delay     (fetch_delay),
		.fetch_ebreak    (fetch_ebreak),
		.bck_req_valid   (bck_req_valid),
		.bck_pc          (bck_pc),
		.bck_opcode      (bck_opcode),
		.bck_rd          (bck_rd),
		.bck_rs1         (bck_rs1),
		.bck_rs2         (bck_rs2),
		.bck_funct3      (bck_funct3),
		.bck_imm         (bck_imm),
		.bck_csr_address (bck_csr_address),
		.bck_wb          (bck_wb)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// galois lfsr, one step per bit taken.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	// {base, random field mask}; branch and jal keep imm[1] clear so targets stay aligned.
	function automatic logic [63:0] template(input logic [3:0] sel);
		case (sel)
			4'd0: return {32'h0000_0033, 32'hffff_ff80};
			4'd1: return {32'h0000_0013, 32'hffff_ff80};
			4'd2: return {32'h0000_0003, 32'hffff_ff80};
			4'd3: return {32'h0000_0023, 32'hffff_ff80};
			4'd4: return {32'h0000_0063, 32'hffff_fe80};
			4'd5: return {32'h0000_006f, 32'hffdf_ff80};
			4'd6: return {32'h0000_0067, 32'hffff_ff80};
			4'd7: return {32'h0000_0037, 32'hffff_ff80};
			4'd8: return {32'h0000_0017, 32'hffff_ff80};
			4'd9: return {32'h0000_1073, 32'hffff_ef80}; // funct3 bit 0 set, never zero.
			4'd10: return {32'h0010_0073, 32'h0000_0000};
			4'd11: return {32'h0000_007f, 32'hffff_ff80};
			4'd12: return {32'h0000_0073, 32'h0000_0000}; // ecall decodes as illegal.
			4'd13: return {32'h0000_0013, 32'hffff_ff80};
			4'd14: return {32'h0000_0033, 32'hffff_ff80};
			default: return {32'h0000_0003, 32'hffff_ff80};
		endcase
	endfunction

	function automatic logic [31:0] gen_word();
		logic [63:0] t;
		logic [31:0] fill;
		t = template(rand_bits(4));
		fill = rand_bits(32);
		return t[63:32] | (fill & t[31:0]);
	endfunction

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		if (image.exists(addr)) begin
			return image[addr];
		end
		return 32'h0000_007f;
	endfunction

	function automatic fields_t decode_ref(input logic [31:0] w);
		fields_t     f;
		logic [31:0] imm_i;
		imm_i = {{20{w[31]}}, w[31:20]};
		f.rd = w[11:7];
		f.rs1 = w[19:15];
		f.rs2 = w[24:20];
		f.funct3 = w[14:12];
		f.csr_address = w[31:20];
		f.opcode = op_illegal;
		f.imm = 32'h0;
		case (w[6:0])
			7'h33: f.opcode = op_alu;
			7'h13: begin
				f.opcode = op_alu_imm;
				f.imm = imm_i;
			end
			7'h03: begin
				f.opcode = op_load;
				f.imm = imm_i;
			end
			7'h23: begin
				f.opcode = op_store;
				f.imm = {{20{w[31]}}, w[31:25], w[11:7]};
			end
			7'h63: begin
				f.opcode = op_branch;
				f.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			end
			7'h6f: begin
				f.opcode = op_jal;
				f.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			7'h67: begin
				f.opcode = op_jalr;
				f.imm = imm_i;
			end
			7'h37: begin
				f.opcode = op_lui;
				f.imm = {w[31:12], 12'h0};
			end
			7'h17: begin
				f.opcode = op_auipc;
				f.imm = {w[31:12], 12'h0};
			end
			7'h73: begin
				if (w[14:12] != 3'd0) begin
					f.opcode = op_csr;
					f.imm = imm_i;
				end else if (w == 32'h0010_0073) begin
					f.opcode = op_ebreak;
					f.imm = imm_i;
				end
			end
			default: f.opcode = op_illegal;
		endcase
		f.wb = f.opcode inside {op_alu, op_alu_imm, op_load, op_jal, op_jalr, op_lui,
			op_auipc, op_csr};
		return f;
	endfunction

	task automatic drive_inputs();
		#2;
		icache_rsp_valid = 1'b0;
		redirect_valid = 1'b0;
		if (rsp_cnt > 0) begin
			rsp_cnt--;
			if (rsp_cnt == 0) begin
				icache_rsp_valid = 1'b1;
				icache_rsp_data = word_at(rsp_addr);
			end
		end
		if (redir_cnt > 0) begin
			redir_cnt--;
			if (redir_cnt == 0) begin
				redirect_valid = 1'b1;
				redirect_pc = redir_target;
			end
		end
		freeze = rand_bits(3) == 32'd0;
		exe_branch_stall = rand_bits(3) == 32'd0;
	endtask

	// cache and back-end models react to what the DUT presents before the next edge.
	task automatic model_cache_and_back_end();
		fields_t f;
		@(negedge clk);
		if (icache_req_valid) begin
			if (rsp_cnt > 0) begin
				err_count++;
				$display("Mismatch at %0t: second cache request while one is outstanding",
					$time);
			end
			if (!image.exists(icache_req_addr)) begin
				image[icache_req_addr] = gen_word();
			end
			rsp_addr = icache_req_addr;
			rsp_cnt = 1 + int'(rand_bits(2));
		end
		if (bck_req_valid && !freeze && bck_opcode inside {op_branch, op_jal, op_jalr}) begin
			f = decode_ref(word_at(bck_pc));
			redir_cnt = 1 + int'(rand_bits(2)) % 3;
			if (bck_opcode == op_jalr) begin
				redir_target = rand_bits(30) << 2;
			end else if (bck_opcode == op_branch && rand_bits(1) == 32'd0) begin
				redir_target = bck_pc + 32'd4; // not taken.
			end else begin
				redir_target = bck_pc + f.imm;
			end
		end
	endtask

	always @(negedge clk) begin : compare_outputs
		fields_t exp_f;
		fields_t got_f;
		logic    fetch_hold;
		got_f = {bck_opcode, bck_rd, bck_rs1, bck_rs2, bck_funct3, bck_imm, bck_csr_address,
			bck_wb};
		fetch_hold = freeze || exe_branch_stall;
		if (!arst_n) begin
			rsp_open = 1'b0;
			rsp_stale = 1'b0;
			rsp_parked = 1'b0;
			if (icache_req_valid || bck_req_valid || fetch_ebreak) begin
				err_count++;
				$display("Mismatch at %0t: outputs are not low during reset", $time);
			end
		end else begin
			if (fetch_delay !== (rsp_open || rsp_parked)) begin
				err_count++;
				$display("Mismatch at %0t: fetch_delay expected %b got %b", $time,
					rsp_open || rsp_parked, fetch_delay);
			end
			if (rsp_parked) begin
				rsp_parked = fetch_hold && !redirect_valid;
			end else if (icache_rsp_valid && rsp_open && !rsp_stale && !redirect_valid
				&& fetch_hold) begin
				rsp_parked = 1'b1; // a frozen fetch keeps the word.
			end
			if (icache_rsp_valid) begin
				rsp_open = 1'b0;
				rsp_stale = 1'b0;
			end else if (redirect_valid && rsp_open) begin
				rsp_stale = 1'b1;
			end
			if (icache_req_valid) begin
				rsp_open = 1'b1;
			end
			if (icache_req_valid && !first_req_seen) begin
				first_req_seen = 1'b1;
				if (icache_req_addr !== RESET_PC) begin
					err_count++;
					$display("Mismatch at %0t: first fetch address %h", $time, icache_req_addr);
				end
			end
			if (prev_freeze
				&& {bck_req_valid, bck_pc, got_f} !== {prev_valid, prev_pc, prev_out}) begin
				err_count++;
				$display("Mismatch at %0t: output changed while frozen", $time);
			end else if (prev_stall && !prev_freeze && bck_req_valid) begin
				err_count++;
				$display("Mismatch at %0t: valid output after a branch stall cycle", $time);
			end
			if (fetch_ebreak) begin
				if (!(bck_req_valid && bck_opcode == op_ebreak) || ebreak_pulse_seen) begin
					err_count++;
					$display("Mismatch at %0t: ebreak pulse without a new ebreak at the output",
						$time);
				end
				ebreak_pulse_seen = 1'b1;
			end
			if (bck_req_valid && !freeze) begin
				exp_f = decode_ref(word_at(bck_pc));
				if (redirect_pending) begin
					err_count++;
					$display("Mismatch at %0t: pc %h left before the pending redirect", $time,
						bck_pc);
				end
				if (bck_pc !== exp_pc) begin
					err_count++;
					$display("Mismatch at %0t: pc expected %h got %h", $time, exp_pc, bck_pc);
				end
				if (got_f !== exp_f) begin
					err_count++;
					$display("Mismatch at %0t: pc %h word %h expected %h got %h", $time, bck_pc,
						word_at(bck_pc), exp_f, got_f);
				end
				if (exp_f.opcode == op_ebreak) begin
					if (!ebreak_pulse_seen) begin
						err_count++;
						$display("Mismatch at %0t: ebreak at pc %h gave no pulse", $time, bck_pc);
					end
					ebreak_pulse_seen = 1'b0;
				end
				class_count[exp_f.opcode]++;
				if (exp_f.opcode inside {op_branch, op_jal, op_jalr}) begin
					redirect_pending = 1'b1;
				end else begin
					exp_pc = exp_pc + 32'd4;
				end
				accepted++;
			end
			if (redirect_valid) begin
				exp_pc = redirect_pc;
				redirect_pending = 1'b0;
			end
		end
		prev_out = got_f;
		prev_valid = bck_req_valid;
		prev_pc = bck_pc;
		prev_freeze = freeze;
		prev_stall = exe_branch_stall;
	end

	initial begin
		lfsr = 32'h90e7;
		arst_n = 1'b0;
		freeze = 1'b0;
		exe_branch_stall = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = 32'h0;
		icache_rsp_valid = 1'b0;
		icache_rsp_data = 32'h0;
		err_count = 0;
		accepted = 0;
		for (int i = 0; i < 16; i++) begin
			class_count[i] = 0;
		end
		exp_pc = RESET_PC;
		redirect_pending = 1'b0;
		ebreak_pulse_seen = 1'b0;
		first_req_seen = 1'b0;
		prev_out = '0;
		prev_valid = 1'b0;
		prev_pc = 32'h0;
		prev_freeze = 1'b0;
		prev_stall = 1'b0;
		rsp_cnt = 0;
		redir_cnt = 0;
		rsp_addr = 32'h0;
		redir_target = 32'h0;
		timed_out = 1'b0;
		cycles = 0;
		idle_cycles = 0;
		last_accepted = 0;
		rsp_open = 1'b0;
		rsp_stale = 1'b0;
		rsp_parked = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		arst_n = 1'b1;
		while (accepted < N_REQ && !timed_out) begin
			@(posedge clk);
			cycles++;
			idle_cycles = (accepted == last_accepted) ? idle_cycles + 1 : 0;
			last_accepted = accepted;
			if (idle_cycles > 200 || cycles > 50000) begin
				timed_out = 1'b1;
			end else begin
				drive_inputs();
				model_cache_and_back_end();
			end
		end
		if (timed_out) begin
			err_count++;
			$display("Error: timeout while waiting for requests at the back end");
		end
		for (int i = 0; i < 12; i++) begin
			if (class_count[i] == 0) begin
				err_count++;
				$display("Error: opcode class %0d never reached the output", i);
			end
		end
		$display("requests checked %0d, cycles %0d, errors %0d", accepted, cycles, err_count);
		if (err_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: sources.f
hw/fe_pkg.sv
hw/fe_req_if.sv
hw/fe_fetch.sv
hw/fe_fd_reg.sv
hw/fe_decode.sv
hw/fe_de_reg.sv
hw/front_end.sv
verif/front_end_sva.sv
verif/tb_front_end.sv

// File: Bender.yml
package:
  name: front_end

sources:
  - hw/fe_pkg.sv
  - hw/fe_req_if.sv
  - hw/fe_fetch.sv
  - hw/fe_fd_reg.sv
  - hw/fe_decode.sv
  - hw/fe_de_reg.sv
  - hw/front_end.sv
  - target: simulation
    files:
      - verif/front_end_sva.sv
      - verif/tb_front_end.sv
